/* vlog.f */
hw/nrx_pkg.sv
hw/nrx_hvgen.sv
hw/nrx_bus_decode.sv
hw/nrx_latch_ctrl.sv
hw/nrx_shared_ram.sv
hw/nrx_color_fetch.sv
hw/nrx_top.sv
tests/tb_nrx_top.sv

/* run.sh */
#!/bin/sh
# Build the board testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module tb_nrx_top -f vlog.f -o sim_nrx \
	&& ./obj_dir/sim_nrx || exit 1

/* tests/tb_nrx_top.sv */
//------------------------------
// Board testbench
// AXI4-Lite host, RAM, inputs, latches, irq, raster, colour
//------------------------------
`timescale 1ns/1ps

module tb_nrx_top import nrx_pkg::*; ();

	localparam int BUS_TMO = 64;                              // Cycles per bus wait
	localparam int FRAME   = int'(H_TOTAL) * int'(V_TOTAL);   // Cycles per frame
	localparam int CELLS   = int'(V_ACTIVE) / 8 * int'(CELL_COLS);
	localparam int SIG_HS  = 0;
	localparam int SIG_VS  = 1;
	localparam int SIG_VB  = 2;

	logic              CCLK;
	logic              reset;
	logic              awvalid, wvalid, arvalid, bready, rready;
	logic [ADDR_W-1:0] awaddr, araddr;
	logic [DATA_W-1:0] wdata;
	logic              awready, wready, arready, bvalid, rvalid;
	logic [1:0]        bresp, rresp;
	logic [DATA_W-1:0] rdata;
	logic [7:0]        ctr1, ctr2, dsw;
	logic              hsync, vsync, hblank, vblank;
	logic [2:0]        r, g;
	logic [1:0]        b;
	logic              irq, bang;
	logic [1:0]        lamp;

	logic [7:0]  model [0:(1 << RAM_AW) - 1];   // Expected work RAM contents
	logic [10:0] ram_addr [0:31];
	logic [15:0] lfsr;

	nrx_top u_nrx_top (.*);

	initial begin
		CCLK = 1'b0;
		forever #4 CCLK = ~CCLK;   // 8 ns period
	end

	//------------------------------
	// Helpers
	//------------------------------
	// Galois LFSR, one step per bit taken
	function automatic logic [15:0] rand_bits(input int nbits);
		logic [15:0] v;
		v = '0;
		repeat (nbits) begin
			v    = {v[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic check_val(input string test, input logic [31:0] want,
			input logic [31:0] got);
		assert (got === want) else begin
			$display("Fail %s: expected %0h, actual %0h", test, want, got);
			$display("test failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout: %s", what);
		$display("test failed");
		$fatal(1, "wait timed out");
	endtask

	function automatic logic probe(input int sel);
		case (sel)
			SIG_HS:  return hsync;
			SIG_VS:  return vsync;
			default: return vblank;    // Delayed output
		endcase
	endfunction

	// Wait for a rising or falling edge, sampled on falling CCLK
	task automatic wait_edge(input int sel, input logic rise, input int limit,
			output int cycles);
		logic prev;
		logic cur;
		logic done;
		prev   = probe(sel);
		cycles = 0;
		do begin
			@(negedge CCLK);
			cycles++;
			if (cycles > limit)
				timeout_fail("raster output edge never came");
			cur  = probe(sel);
			done = rise ? (cur && !prev) : (!cur && prev);
			prev = cur;
		end while (!done);
	endtask

	//------------------------------
	// AXI4-Lite host
	//------------------------------
	// Drives and samples on falling edges only
	task automatic host_write(input logic [15:0] a, input logic [7:0] d);
		int n;
		awaddr  = a;
		wdata   = d;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n = 0;
		#1;                                 // Ready is combinational from valid
		while (!(awready && wready)) begin
			@(negedge CCLK);
			n++;
			if (n > BUS_TMO)
				timeout_fail("write address and data not accepted");
		end
		@(negedge CCLK);                    // Taken at the rising edge between
		awvalid = 1'b0;
		wvalid  = 1'b0;
		bready  = 1'b1;
		n = 0;
		while (!bvalid) begin
			@(negedge CCLK);
			n++;
			if (n > BUS_TMO)
				timeout_fail("no write response");
		end
		check_val("write resp", 32'(2'b00), 32'(bresp));
		@(negedge CCLK);
		bready = 1'b0;
	endtask

	task automatic host_read(input logic [15:0] a, output logic [7:0] d);
		int n;
		araddr  = a;
		arvalid = 1'b1;
		n = 0;
		#1;                                 // Ready is combinational from valid
		while (!arready) begin
			@(negedge CCLK);
			n++;
			if (n > BUS_TMO)
				timeout_fail("read address not accepted");
		end
		@(negedge CCLK);                    // Taken at the rising edge between
		arvalid = 1'b0;
		rready  = 1'b1;
		n = 0;
		while (!rvalid) begin
			@(negedge CCLK);
			n++;
			if (n > BUS_TMO)
				timeout_fail("no read response");
		end
		d = rdata;
		check_val("read resp", 32'(2'b00), 32'(rresp));
		@(negedge CCLK);
		rready = 1'b0;
	endtask

	//------------------------------
	// Raster and colour
	//------------------------------
	// Hsync rises between two vsync rises
	task automatic count_lines(output int lines, output int cycles);
		logic hs_q;
		logic vs_q;
		logic v_rise;
		hs_q   = hsync;
		vs_q   = vsync;
		lines  = 0;
		cycles = 0;
		do begin
			@(negedge CCLK);
			cycles++;
			if (cycles > 2 * FRAME)
				timeout_fail("vsync period never ended");
			if (hsync && !hs_q)
				lines++;
			v_rise = vsync && !vs_q;
			hs_q   = hsync;
			vs_q   = vsync;
		end while (!v_rise);
	endtask

	// One frame of pixels, counters restart on blank falling edges
	task automatic check_frame();
		int         x;
		int         y;
		int         n;
		logic       hb_q;
		logic       vb_q;
		logic [7:0] want;
		wait_edge(SIG_VB, 1'b0, 2 * FRAME, n);
		x    = 0;
		y    = 0;
		hb_q = hblank;
		vb_q = vblank;
		repeat (FRAME) begin
			if (!hblank && !vblank)
				want = model[(y / 8) * int'(CELL_COLS) + x / 8];
			else
				want = 8'h00;                     // Black in blanking
			check_val("colour", 32'(want), 32'({b, g, r}));
			@(negedge CCLK);
			if (hb_q && !hblank) begin           // New line
				x = 0;
				y = (vb_q && !vblank) ? 0 : y + 1;
			end else begin
				x++;
			end
			hb_q = hblank;
			vb_q = vblank;
		end
	endtask

	// Host reads racing the video fetches
	task automatic read_during_fetch();
		logic [10:0] a;
		logic [7:0]  d;
		int          n;
		wait_edge(SIG_VB, 1'b0, 2 * FRAME, n);
		repeat (48) begin
			a = 11'(int'(rand_bits(11)) % CELLS);
			host_read(RAM_BASE + 16'(a), d);
			check_val("colour host read", 32'(model[a]), 32'(d));
		end
	endtask

	//------------------------------
	// Sequence
	//------------------------------
	initial begin
		logic [7:0] d;
		logic [7:0] v;
		int         i;
		int         n;
		int         lines;
		reset   = 1'b1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		arvalid = 1'b0;
		bready  = 1'b0;
		rready  = 1'b0;
		awaddr  = '0;
		araddr  = '0;
		wdata   = '0;
		ctr1    = '0;
		ctr2    = '0;
		dsw     = '0;
		lfsr    = 16'd40915;
		repeat (2) @(negedge CCLK);
		reset = 1'b0;
		check_val("reset outputs", 32'(0), 32'({irq, lamp, bang, bvalid, rvalid}));

		// RAM read-back at random addresses
		for (i = 0; i < 32; i++) begin
			ram_addr[i] = 11'(rand_bits(11));
			d = 8'(rand_bits(8));
			model[ram_addr[i]] = d;
			host_write(RAM_BASE + 16'(ram_addr[i]), d);
		end
		for (i = 0; i < 32; i++) begin
			host_read(RAM_BASE + 16'(ram_addr[i]), d);
			check_val("ram readback", 32'(model[ram_addr[i]]), 32'(d));
		end

		// Unmapped: same low bits as a RAM word, outside the window
		host_write(16'h1800 | 16'(ram_addr[0]), ~model[ram_addr[0]]);
		host_read(RAM_BASE + 16'(ram_addr[0]), d);
		check_val("unmapped write", 32'(model[ram_addr[0]]), 32'(d));
		host_write(16'hC000, 8'hFF);
		host_read(16'hC000, d);
		check_val("unmapped read", 32'(0), 32'(d));
		host_read(16'hA200, d);
		check_val("unmapped read", 32'(0), 32'(d));

		// Input ports
		ctr1 = 8'(rand_bits(8));
		ctr2 = 8'(rand_bits(8));
		dsw  = 8'(rand_bits(8));
		host_read(16'hA000, d);
		check_val("inputs ctr1", 32'(ctr1), 32'(d));
		host_read(16'hA080, d);
		check_val("inputs ctr2", 32'(ctr2), 32'(d));
		host_read(16'hA100, d);
		check_val("inputs dsw", 32'(dsw), 32'(d));

		// Latches, bit 0 set then clear
		for (i = 0; i < 2; i++) begin
			v = {7'(rand_bits(7)), (i == 0)};
			host_write(16'hA180, v);
			check_val("latch bang", 32'(v[0]), 32'(bang));
			host_write(16'hA184, v);
			check_val("latch lamp0", 32'(v[0]), 32'(lamp[0]));
			host_write(16'hA185, v);
			check_val("latch lamp1", 32'(v[0]), 32'(lamp[1]));
		end

		// Interrupt
		host_write(16'hA181, 8'h01);
		wait_edge(SIG_VB, 1'b1, FRAME + int'(H_TOTAL), n);
		check_val("irq on vblank", 32'(1), 32'(irq));
		host_write(16'hA181, 8'h01);                 // Ack clears pending
		check_val("irq ack", 32'(0), 32'(irq));
		host_write(16'hA181, 8'h00);
		repeat (FRAME + int'(H_TOTAL)) begin
			@(negedge CCLK);
			check_val("irq masked", 32'(0), 32'(irq));
		end

		// Raster timing
		wait_edge(SIG_HS, 1'b1, 2 * int'(H_TOTAL), n);
		wait_edge(SIG_HS, 1'b1, 2 * int'(H_TOTAL), n);
		check_val("line length", 32'(H_TOTAL), 32'(n));
		wait_edge(SIG_VS, 1'b1, 2 * FRAME, n);
		count_lines(lines, n);
		check_val("lines per frame", 32'(V_TOTAL), 32'(lines));
		check_val("frame length", 32'(FRAME), 32'(n));

		// Colour, cell RAM filled first
		for (i = 0; i < CELLS; i++) begin
			d = 8'(rand_bits(8));
			model[i] = d;
			host_write(RAM_BASE + 16'(i), d);
		end
		fork
			check_frame();
			read_during_fetch();
		join

		$display("test passed");
		$finish;
	end

endmodule

/* hw/nrx_top.sv */
//------------------------------
// Board top level
// Host bus, work RAM, latches, raster, colour
//------------------------------
`timescale 1ns/1ps

module nrx_top import nrx_pkg::*; (
	input  logic              CCLK,
	input  logic              reset,
	// AXI4-Lite slave
	input  logic              awvalid,
	input  logic [ADDR_W-1:0] awaddr,
	input  logic              wvalid,
	input  logic [DATA_W-1:0] wdata,
	input  logic              arvalid,
	input  logic [ADDR_W-1:0] araddr,
	input  logic              bready,
	input  logic              rready,
	output logic              awready,
	output logic              wready,
	output logic              arready,
	output logic              bvalid,
	output logic [1:0]        bresp,
	output logic              rvalid,
	output logic [DATA_W-1:0] rdata,
	output logic [1:0]        rresp,
	// Board I/O
	input  logic [7:0]        ctr1,
	input  logic [7:0]        ctr2,
	input  logic [7:0]        dsw,
	output logic              hsync,
	output logic              vsync,
	output logic              hblank,
	output logic              vblank,
	output logic [2:0]        r,
	output logic [2:0]        g,
	output logic [1:0]        b,
	output logic              irq,
	output logic [1:0]        lamp,
	output logic              bang
);

	raster_t           raster;
	bus_req_t          lat_req;
	ram_req_t          host_req;
	ram_req_t          video_req;
	logic [DATA_W-1:0] lat_rdata;
	logic [DATA_W-1:0] ram_rdata;   // Shared by both RAM masters
	logic              host_grant;
	logic              hblank_raw;  // Undelayed, from counters
	logic              vblank_raw;

	nrx_hvgen u_hvgen (
		.CCLK(CCLK), .reset(reset), .raster(raster),
		.hsync(hsync), .vsync(vsync), .hblank(hblank_raw), .vblank(vblank_raw)
	);

	nrx_bus_decode u_bus_decode (
		.CCLK(CCLK), .reset(reset),
		.awvalid(awvalid), .awaddr(awaddr), .wvalid(wvalid), .wdata(wdata),
		.arvalid(arvalid), .araddr(araddr), .bready(bready), .rready(rready),
		.awready(awready), .wready(wready), .arready(arready),
		.bvalid(bvalid), .bresp(bresp), .rvalid(rvalid), .rdata(rdata), .rresp(rresp),
		.lat_req(lat_req), .lat_rdata(lat_rdata),
		.host_req(host_req), .host_grant(host_grant), .ram_rdata(ram_rdata)
	);

	nrx_latch_ctrl u_latch_ctrl (
		.CCLK(CCLK), .reset(reset), .lat_req(lat_req), .raster(raster),
		.ctr1(ctr1), .ctr2(ctr2), .dsw(dsw),
		.lat_rdata(lat_rdata), .irq(irq), .lamp(lamp), .bang(bang)
	);

	nrx_shared_ram u_shared_ram (
		.CCLK(CCLK), .reset(reset), .host_req(host_req), .video_req(video_req),
		.host_grant(host_grant), .rdata(ram_rdata)
	);

	// Blank outputs come out delayed to match the colour
	nrx_color_fetch u_color_fetch (
		.CCLK(CCLK), .reset(reset), .raster(raster), .rdata(ram_rdata),
		.hblank_in(hblank_raw), .vblank_in(vblank_raw), .video_req(video_req),
		.r(r), .g(g), .b(b), .hblank(hblank), .vblank(vblank)
	);

endmodule

/* hw/nrx_color_fetch.sv */
//------------------------------
// Colour fetch
// One work RAM byte per 8x8 cell, drives {b,g,r}
//------------------------------
`timescale 1ns/1ps

module nrx_color_fetch import nrx_pkg::*; (
	input  logic              CCLK,
	input  logic              reset,
	input  raster_t           raster,
	input  logic [DATA_W-1:0] rdata,
	input  logic              hblank_in,
	input  logic              vblank_in,
	output ram_req_t          video_req,
	output logic [2:0]        r,
	output logic [2:0]        g,
	output logic [1:0]        b,
	output logic              hblank,
	output logic              vblank
);

	logic [5:0]        row;
	logic [5:0]        col;
	logic [RAM_AW-1:0] cell_addr;
	logic              fetch;
	logic              fetch_d1;     // RAM data valid this cycle
	logic              active_d1;
	logic [DATA_W-1:0] hold_q;       // Byte of current cell
	logic [DATA_W-1:0] color_q;
	logic [1:0]        hblank_d;
	logic [1:0]        vblank_d;

	//------------------------------
	// Cell address and request
	//------------------------------
	assign row       = raster.vpos[8:3];
	assign col       = raster.hpos[8:3];
	assign cell_addr = RAM_AW'(row) * RAM_AW'(CELL_COLS) + RAM_AW'(col);
	assign fetch     = raster.active && (raster.hpos[2:0] == 3'd0); // First pixel of cell

	always_comb begin
		video_req.valid = fetch;
		video_req.we    = 1'b0;                  // Read only
		video_req.addr  = cell_addr;
		video_req.wdata = '0;
	end

	//------------------------------
	// Pixel pipeline, two stages
	//------------------------------
	always_ff @(posedge CCLK) begin
		if (reset) begin
			fetch_d1  <= 1'b0;
			active_d1 <= 1'b0;
			color_q   <= '0;
			hblank_d  <= '0;
			vblank_d  <= '0;
		end else begin
			fetch_d1  <= fetch;
			active_d1 <= raster.active;
			if (!active_d1)
				color_q <= '0;                    // Black in blanking
			else
				color_q <= fetch_d1 ? rdata : hold_q;
			hblank_d <= {hblank_d[0], hblank_in};
			vblank_d <= {vblank_d[0], vblank_in};
		end
	end

	always_ff @(posedge CCLK) begin
		if (fetch_d1)
			hold_q <= rdata;                      // Keep for rest of cell
	end

	assign {b, g, r} = color_q;
	assign hblank    = hblank_d[1];
	assign vblank    = vblank_d[1];

endmodule

/* hw/nrx_shared_ram.sv */
//------------------------------
// Shared work RAM
// 2 KB single port, colour fetch has priority
//------------------------------
`timescale 1ns/1ps

module nrx_shared_ram import nrx_pkg::*; (
	input  logic              CCLK,
	input  logic              reset,
	input  ram_req_t          host_req,
	input  ram_req_t          video_req,
	output logic              host_grant,
	output logic [DATA_W-1:0] rdata
);

	//------------------------------
	// Arbiter
	//------------------------------
	ram_req_t sel;    // Request served this cycle

	// Video asks at most one cycle in eight, host never starves
	assign host_grant = host_req.valid && !video_req.valid;
	assign sel        = video_req.valid ? video_req : host_req;

	//------------------------------
	// Storage
	//------------------------------
	logic [DATA_W-1:0] mem [0:(1 << RAM_AW) - 1];

	always_ff @(posedge CCLK) begin
		if (sel.valid && sel.we)
			mem[sel.addr] <= sel.wdata;
	end

	// Read port register, old data on a write
	always_ff @(posedge CCLK) begin
		if (reset)
			rdata <= '0;
		else if (sel.valid)
			rdata <= mem[sel.addr];
	end

endmodule

/* hw/nrx_latch_ctrl.sv */
//------------------------------
// Control latches and input ports
// Interrupt, lamps, bang, CTR/DSW read mux
//------------------------------
`timescale 1ns/1ps

module nrx_latch_ctrl import nrx_pkg::*; (
	input  logic              CCLK,
	input  logic              reset,
	input  bus_req_t          lat_req,
	input  raster_t           raster,
	input  logic [7:0]        ctr1,
	input  logic [7:0]        ctr2,
	input  logic [7:0]        dsw,
	output logic [DATA_W-1:0] lat_rdata,
	output logic              irq,
	output logic [1:0]        lamp,
	output logic              bang
);

	logic       inte;    // Interrupt enable
	logic       intl;    // Pending, set at vblank start
	logic       in_lat;
	logic       in_inp;
	logic [3:0] offs;

	assign in_lat = (lat_req.addr[ADDR_W-1:4] == LAT_BASE[ADDR_W-1:4]);
	assign in_inp = (lat_req.addr[ADDR_W-1:9] == INP_BASE[ADDR_W-1:9]);
	assign offs   = lat_req.addr[3:0];

	//------------------------------
	// Latch writes
	//------------------------------
	always_ff @(posedge CCLK) begin
		if (reset) begin
			inte <= 1'b0;
			intl <= 1'b0;
			lamp <= 2'b00;
			bang <= 1'b0;
		end else begin
			if (raster.vblk_start)
				intl <= 1'b1;
			if (lat_req.op == OP_WRITE && in_lat) begin
				case (offs)
					LAT_BANG: bang <= lat_req.wdata[0];
					LAT_IE: begin
						inte <= lat_req.wdata[0];
						intl <= 1'b0;            // Ack beats a same-cycle set
					end
					LAT_LP0:  lamp[0] <= lat_req.wdata[0];
					LAT_LP1:  lamp[1] <= lat_req.wdata[0];
					default: ;
				endcase
			end
		end
	end

	assign irq = intl && inte;   // Level to host

	//------------------------------
	// Read mux
	//------------------------------
	always_comb begin
		lat_rdata = '0;
		if (in_lat) begin
			case (offs)
				LAT_BANG: lat_rdata[0] = bang;
				LAT_IE:   lat_rdata[0] = inte;
				LAT_LP0:  lat_rdata[0] = lamp[0];
				LAT_LP1:  lat_rdata[0] = lamp[1];
				default:  lat_rdata = '0;
			endcase
		end else if (in_inp) begin
			// Bit 8 picks DSW, else bit 7 picks CTR2
			lat_rdata = lat_req.addr[8] ? dsw : (lat_req.addr[7] ? ctr2 : ctr1);
		end
	end

endmodule

/* hw/nrx_bus_decode.sv */
//------------------------------
// AXI4-Lite slave and address decoder
// One access at a time to RAM, latches or inputs
//------------------------------
`timescale 1ns/1ps

module nrx_bus_decode import nrx_pkg::*; (
	input  logic              CCLK,
	input  logic              reset,
	// AXI4-Lite slave
	input  logic              awvalid,
	input  logic [ADDR_W-1:0] awaddr,
	input  logic              wvalid,
	input  logic [DATA_W-1:0] wdata,
	input  logic              arvalid,
	input  logic [ADDR_W-1:0] araddr,
	input  logic              bready,
	input  logic              rready,
	output logic              awready,
	output logic              wready,
	output logic              arready,
	output logic              bvalid,
	output logic [1:0]        bresp,
	output logic              rvalid,
	output logic [DATA_W-1:0] rdata,
	output logic [1:0]        rresp,
	// Latch / input peer
	output bus_req_t          lat_req,
	input  logic [DATA_W-1:0] lat_rdata,
	// Work RAM host port
	output ram_req_t          host_req,
	input  logic              host_grant,
	input  logic [DATA_W-1:0] ram_rdata
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ACCESS,     // Issue to peer
		S_RAM_WAIT,   // Hold RAM request, then take data
		S_RESP        // B or R valid
	} state_e;

	state_e            state;
	region_e           region;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [DATA_W-1:0] rdata_q;
	logic              is_read;
	logic              granted;   // Grant seen, data due this cycle
	logic              rd_take;
	logic              wr_take;

	// Latch window sits inside the input window, so check it first
	function automatic region_e classify(input logic [ADDR_W-1:0] a);
		region_e r;
		r = REG_NONE;
		if (a[ADDR_W-1:4] == LAT_BASE[ADDR_W-1:4])
			r = REG_LAT;
		else if (a[ADDR_W-1:RAM_AW] == RAM_BASE[ADDR_W-1:RAM_AW])
			r = REG_RAM;
		else if (a[ADDR_W-1:9] == INP_BASE[ADDR_W-1:9])   // 512-byte window
			r = REG_INP;
		return r;
	endfunction

	assign region = classify(addr_q);

	//------------------------------
	// Handshakes
	//------------------------------
	assign rd_take = (state == S_IDLE) && arvalid;               // Read wins
	assign wr_take = (state == S_IDLE) && awvalid && wvalid && !arvalid;

	assign arready = rd_take;
	assign awready = wr_take;
	assign wready  = wr_take;

	assign bvalid = (state == S_RESP) && !is_read;
	assign rvalid = (state == S_RESP) && is_read;
	assign rdata  = rdata_q;
	assign bresp  = 2'b00;   // Always OKAY
	assign rresp  = 2'b00;

	//------------------------------
	// Sequencer
	//------------------------------
	always_ff @(posedge CCLK) begin
		if (reset) begin
			state   <= S_IDLE;
			is_read <= 1'b0;
			granted <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (rd_take || wr_take) begin
						is_read <= rd_take;
						state   <= S_ACCESS;
					end
				end
				S_ACCESS: state <= (region == REG_RAM) ? S_RAM_WAIT : S_RESP;
				S_RAM_WAIT: begin
					if (granted) begin
						granted <= 1'b0;
						state   <= S_RESP;
					end else if (host_grant) begin
						granted <= 1'b1;
					end
				end
				S_RESP: if (is_read ? rready : bready) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Address, write data and read data capture
	always_ff @(posedge CCLK) begin
		if (rd_take) begin
			addr_q <= araddr;
		end else if (wr_take) begin
			addr_q  <= awaddr;
			wdata_q <= wdata;
		end
		if (state == S_ACCESS) // Unmapped reads give zero
			rdata_q <= (region == REG_INP || region == REG_LAT) ? lat_rdata : '0;
		else if (state == S_RAM_WAIT && granted)
			rdata_q <= ram_rdata;
	end

	//------------------------------
	// Peer requests
	//------------------------------
	always_comb begin
		lat_req.op    = OP_IDLE;
		lat_req.addr  = addr_q;
		lat_req.wdata = wdata_q;
		if (state == S_ACCESS && (region == REG_INP || region == REG_LAT))
			lat_req.op = is_read ? OP_READ : OP_WRITE;

		host_req.valid = (state == S_RAM_WAIT) && !granted; // Held until grant
		host_req.we    = !is_read;
		host_req.addr  = addr_q[RAM_AW-1:0];
		host_req.wdata = wdata_q;
	end

endmodule

/* hw/nrx_hvgen.sv */
//------------------------------
// Raster timing generator
// Pixel and line counters, sync and blank decode
//------------------------------
`timescale 1ns/1ps

module nrx_hvgen import nrx_pkg::*; (
	input  logic    CCLK,
	input  logic    reset,
	output raster_t raster,
	output logic    hsync,
	output logic    vsync,
	output logic    hblank,
	output logic    vblank
);

	logic [8:0] hcnt;   // Pixel within line
	logic [8:0] vcnt;   // Line within frame
	logic       h_last;
	logic       v_last;

	assign h_last = (hcnt == H_TOTAL - 9'd1);
	assign v_last = (vcnt == V_TOTAL - 9'd1);

	//------------------------------
	// Counters
	//------------------------------
	always_ff @(posedge CCLK) begin
		if (reset) begin
			hcnt <= '0;
			vcnt <= '0;
		end else begin
			if (h_last) begin
				hcnt <= '0;
				vcnt <= v_last ? 9'd0 : vcnt + 9'd1; // Frame wrap
			end else begin
				hcnt <= hcnt + 9'd1;
			end
		end
	end

	//------------------------------
	// Decode
	//------------------------------
	assign hblank = (hcnt >= H_ACTIVE);
	assign vblank = (vcnt >= V_ACTIVE);

	// Active-high sync windows
	assign hsync = (hcnt >= HS_START) && (hcnt < HS_END);
	assign vsync = (vcnt >= VS_START) && (vcnt < VS_END);

	always_comb begin
		raster.hpos       = hcnt;
		raster.vpos       = vcnt;
		raster.active     = !hblank && !vblank;
		raster.vblk_start = (hcnt == 9'd0) && (vcnt == V_ACTIVE); // One-cycle strobe
	end

endmodule

/* hw/nrx_pkg.sv */
//------------------------------
// Board package
// Memory map, raster geometry, bus enums and structs
//------------------------------
package nrx_pkg;

	//------------------------------
	// Bus sizes
	//------------------------------
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;
	localparam int RAM_AW = 11;                  // 2 KB work RAM

	//------------------------------
	// Memory map
	//------------------------------
	localparam logic [ADDR_W-1:0] RAM_BASE = 16'h9800; // 2 KB
	localparam logic [ADDR_W-1:0] INP_BASE = 16'hA000; // 512 bytes
	localparam logic [ADDR_W-1:0] LAT_BASE = 16'hA180; // 16 bytes

	// Latch offsets inside the latch window
	localparam logic [3:0] LAT_BANG = 4'h0;
	localparam logic [3:0] LAT_IE   = 4'h1;
	localparam logic [3:0] LAT_LP0  = 4'h4;
	localparam logic [3:0] LAT_LP1  = 4'h5;

	//------------------------------
	// Raster geometry, one pixel per CCLK
	//------------------------------
	localparam logic [8:0] H_TOTAL  = 9'd384;
	localparam logic [8:0] H_ACTIVE = 9'd288;
	localparam logic [8:0] V_TOTAL  = 9'd264;
	localparam logic [8:0] V_ACTIVE = 9'd224;
	localparam logic [8:0] HS_START = 9'd312;
	localparam logic [8:0] HS_END   = 9'd344;
	localparam logic [8:0] VS_START = 9'd240;
	localparam logic [8:0] VS_END   = 9'd244;
	localparam logic [5:0] CELL_COLS = 6'd36;    // 8-pixel cells per line

	// Which peer owns an address
	typedef enum logic [1:0] {
		REG_NONE,
		REG_RAM,
		REG_INP,
		REG_LAT
	} region_e;

	typedef enum logic [1:0] {
		OP_IDLE,
		OP_READ,
		OP_WRITE
	} bus_op_e;

	// Latch / input port access, one cycle wide
	typedef struct packed {
		bus_op_e           op;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} bus_req_t;

	// Work RAM port request
	typedef struct packed {
		logic              valid;
		logic              we;
		logic [RAM_AW-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} ram_req_t;

	typedef struct packed {
		logic [8:0] hpos;
		logic [8:0] vpos;
		logic       active;      // Inside visible area
		logic       vblk_start;  // First pixel of line V_ACTIVE
	} raster_t;

endpackage
